//--- sim.f
+incdir+.
mpu_pkg.sv
csr_bus_if.sv
region_csr_bank.sv
stack_frame_tracker.sv
region_checker.sv
mpu_top.sv
mpu_assertions.sv
tb_mpu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_mpu -o tb_mpu_sim

./obj_dir/tb_mpu_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- tb_mpu.sv
`timescale 1ns/10ps
`include "mpu_consts.svh"

module tb_mpu import mpu_pkg::*; ();

    localparam int PERIOD        = 100;
    localparam int WORDS         = `MPU_MAPS * `MPU_ROWS;
    localparam int TEST_CYCLES   = 16 + 3 + 64 + 36 + 9 + 16 + 10 + 48;
    localparam int MARGIN_CYCLES = 100;

    logic        clk;
    logic        reset;
    logic [15:0] mem_address;
    logic [15:0] sp;
    op_t         op;
    logic [1:0]  interrupt_prio;
    logic [3:0]  id;
    logic        csr_enable;
    csr_addr_t   csr_addr;
    csr_op_t     csr_op;
    logic [31:0] rs1_data;
    logic [4:0]  rs1_zimm;
    logic [31:0] csr_rdata;
    logic        mem_fault;
    logic        mem_fault_ff;

    // Reference copy of region words, entry stack pointers and expected flags
    logic [31:0] model_words [WORDS];
    logic [15:0] model_slots [`MPU_PRIO_LEVELS];
    logic [1:0]  model_last_prio;
    logic        exp_f;
    logic        exp_ff;
    int          errors;
    int          checks;

    mpu_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * PERIOD);
        $display("Watchdog timeout: the tests did not finish in the expected time");
        $display("Some tests failed");
        $finish;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] t=%0d ns: %s, got %0h expected %0h", $time, what, actual, expected);
        end
    endtask

    function automatic csr_addr_t word_addr(input int idx);
        return csr_addr_t'(int'(`MPU_CSR_BASE) + idx);
    endfunction

    function automatic logic table_hit(input logic en, input csr_addr_t addr);
        int offs;
        offs = int'(addr) - int'(`MPU_CSR_BASE);
        return en && offs >= 0 && offs < WORDS;
    endfunction

    function automatic logic [15:0] current_bound();
        // New priority level sees the incoming sp right away
        if (interrupt_prio != model_last_prio) return sp;
        return model_slots[interrupt_prio];
    endfunction

    function automatic logic expected_fault(input logic [15:0] addr, input op_t o,
                                            input logic [3:0] tid, input logic [15:0] bound);
        logic [31:0] w;
        logic [15:0] last;
        logic        permit;
        if (o != OP_LOAD && o != OP_STORE) return 1'b0;
        if (addr >= `MPU_STACK_TOP && addr <= bound) return 1'b0;
        if (int'(tid) >= `MPU_MAPS) return 1'b1;
        permit = 1'b0;
        for (int r = 0; r < `MPU_ROWS; r++) begin
            w    = model_words[int'(tid) * `MPU_ROWS + r];
            last = w[31:16] + {2'b00, w[15:2]};
            if (addr >= w[31:16] && addr <= last && (o == OP_LOAD ? w[0] : w[1])) begin
                permit = 1'b1;
            end
        end
        return !permit;
    endfunction

    // State change at the rising edge
    task automatic update_model();
        int          idx;
        logic [31:0] opnd;
        logic [31:0] old;
        if (table_hit(csr_enable, csr_addr)) begin
            idx  = int'(csr_addr) - int'(`MPU_CSR_BASE);
            old  = model_words[idx];
            opnd = (csr_op inside {CSRRWI, CSRRSI, CSRRCI}) ? {27'b0, rs1_zimm} : rs1_data;
            case (csr_op)
                CSRRW, CSRRWI: model_words[idx] = opnd;
                CSRRS, CSRRSI: model_words[idx] = old | opnd;
                CSRRC, CSRRCI: model_words[idx] = old & ~opnd;
                default: ;
            endcase
        end
        if (interrupt_prio != model_last_prio) begin
            model_slots[interrupt_prio] = sp;
            model_last_prio = interrupt_prio;
        end
    endtask

    // One clock with the inputs already driven and every output checked
    task automatic tick();
        logic        exp_now;
        logic [31:0] exp_rdata;
        exp_now   = expected_fault(mem_address, op, id, current_bound());
        exp_rdata = table_hit(csr_enable, csr_addr) ?
                    model_words[int'(csr_addr) - int'(`MPU_CSR_BASE)] : 32'd0;
        #10;
        check_value(csr_rdata, exp_rdata, "csr_rdata");
        @(posedge clk);
        update_model();
        exp_ff = exp_f;
        exp_f  = exp_now;
        @(negedge clk);
        check_value(32'(mem_fault), 32'(exp_f), "mem_fault against model");
        check_value(32'(mem_fault_ff), 32'(exp_ff), "mem_fault_ff against model");
    endtask

    task automatic access(input logic [15:0] addr, input op_t o, input logic [3:0] tid,
                          input logic expect_fault, input string what);
        mem_address = addr;
        op          = o;
        id          = tid;
        tick();
        check_value(32'(mem_fault), 32'(expect_fault), what);
    endtask

    task automatic csr_cmd(input csr_addr_t addr, input csr_op_t cop,
                           input logic [31:0] data, input logic [4:0] zimm);
        csr_enable = 1'b1;
        csr_addr   = addr;
        csr_op     = cop;
        rs1_data   = data;
        rs1_zimm   = zimm;
        op         = OP_IMM;
        tick();
        csr_enable = 1'b0;
    endtask

    task automatic write_region(input int map, input int row, input logic [15:0] base,
                                input logic [13:0] len, input logic we, input logic re);
        csr_cmd(word_addr(map * `MPU_ROWS + row), CSRRW, {base, len, we, re}, 5'd0);
    endtask

    task automatic test_reset();
        check_value(32'(mem_fault), 32'd0, "mem_fault after reset");
        check_value(32'(mem_fault_ff), 32'd0, "mem_fault_ff after reset");
        access(16'h0000, OP_LOAD, 4'd0, 1'b1, "load at 0 after reset");
        access(16'h0000, OP_REG, 4'd0, 1'b0, "ALU op after reset");
        access(16'h0600, OP_IMM, 4'd9, 1'b0, "immediate op without a map");
    endtask

    task automatic test_csr_ops();
        int      k;
        int      idx;
        csr_op_t cop;
        idx = 0;
        for (int n = 0; n < 24; n++) begin
            k = n % 6;
            // All six operations in turn on one random word
            if (k == 0) begin
                idx = $urandom_range(0, WORDS - 1);
            end
            cop = csr_op_t'(k < 3 ? k + 1 : k + 2);
            csr_cmd(word_addr(idx), cop, $urandom, 5'($urandom));
        end
        csr_cmd(12'h3FF, CSRRW, $urandom, 5'h1F);
        csr_cmd(word_addr(WORDS), CSRRS, 32'hFFFF_FFFF, 5'h1F);
        csr_cmd(12'hC00, CSRRWI, 32'h0, 5'h15);
        // Nothing may be written while enable is low
        csr_addr = word_addr(0);
        csr_op   = CSRRW;
        rs1_data = 32'hA5A5_5A5A;
        tick();
        // Set with zero reads every word without changing it
        for (int j = 0; j < WORDS; j++) begin
            csr_cmd(word_addr(j), CSRRS, 32'd0, 5'd0);
        end
    endtask

    task automatic clear_table();
        for (int j = 0; j < WORDS; j++) begin
            csr_cmd(word_addr(j), CSRRW, 32'd0, 5'd0);
        end
    endtask

    task automatic test_permissions();
        write_region(0, 0, 16'h0100, 14'h0020, 1'b0, 1'b1);
        write_region(0, 1, 16'h0200, 14'h0020, 1'b1, 1'b0);
        write_region(0, 2, 16'h0300, 14'h0020, 1'b0, 1'b0);
        access(16'h0110, OP_LOAD, 4'd0, 1'b0, "load in read-only region");
        access(16'h0110, OP_STORE, 4'd0, 1'b1, "store in read-only region");
        access(16'h0210, OP_LOAD, 4'd0, 1'b1, "load in write-only region");
        access(16'h0210, OP_STORE, 4'd0, 1'b0, "store in write-only region");
        access(16'h0310, OP_LOAD, 4'd0, 1'b1, "load in disabled region");
        access(16'h0310, OP_STORE, 4'd0, 1'b1, "store in disabled region");
    endtask

    task automatic test_bounds();
        write_region(1, 3, 16'h2000, 14'h0100, 1'b1, 1'b1);
        write_region(2, 0, 16'h3000, 14'h0010, 1'b1, 1'b1);
        access(16'h1FFF, OP_LOAD, 4'd1, 1'b1, "id 1 below base");
        access(16'h2000, OP_LOAD, 4'd1, 1'b0, "id 1 at base");
        access(16'h2100, OP_STORE, 4'd1, 1'b0, "id 1 at base plus length");
        access(16'h2101, OP_STORE, 4'd1, 1'b1, "id 1 past the end");
        access(16'h2000, OP_LOAD, 4'd2, 1'b1, "id 2 in map of id 1");
        access(16'h2100, OP_LOAD, 4'd2, 1'b1, "id 2 at end of map of id 1");
        access(16'h2FFF, OP_LOAD, 4'd2, 1'b1, "id 2 below base");
        access(16'h3000, OP_STORE, 4'd2, 1'b0, "id 2 at base");
        access(16'h3010, OP_LOAD, 4'd2, 1'b0, "id 2 at base plus length");
        access(16'h3011, OP_LOAD, 4'd2, 1'b1, "id 2 past the end");
        access(16'h2000, OP_LOAD, 4'd9, 1'b1, "id 9 selects no map");
        access(16'h3000, OP_STORE, 4'd15, 1'b1, "id 15 selects no map");
    endtask

    task automatic test_stack();
        interrupt_prio = 2'd1;
        sp             = 16'h0800;
        access(16'h0500, OP_LOAD, 4'd9, 1'b0, "stack top on entry cycle");
        access(16'h0800, OP_STORE, 4'd9, 1'b0, "frame bound of priority 1");
        access(16'h04FF, OP_LOAD, 4'd9, 1'b1, "below stack top");
        access(16'h0801, OP_LOAD, 4'd9, 1'b1, "above frame bound");
        interrupt_prio = 2'd2;
        sp             = 16'h0600;
        access(16'h0700, OP_LOAD, 4'd9, 1'b1, "above frame of priority 2");
        access(16'h0600, OP_LOAD, 4'd9, 1'b0, "frame bound of priority 2");
        interrupt_prio = 2'd1;
        sp             = 16'h0800;
        access(16'h0800, OP_LOAD, 4'd9, 1'b0, "back at priority 1");
        sp = 16'h0A00;
        access(16'h0900, OP_LOAD, 4'd9, 1'b1, "recorded bound holds while sp moves");
        interrupt_prio = 2'd0;
        sp             = 16'h0000;
        access(16'h0500, OP_LOAD, 4'd9, 1'b1, "empty window at priority 0");
    endtask

    function automatic op_t random_op();
        case ($urandom_range(0, 3))
            0: return OP_LOAD;
            1: return OP_STORE;
            2: return OP_IMM;
            default: return OP_REG;
        endcase
    endfunction

    // Back to back accesses with both pipeline stages checked every cycle
    task automatic test_stream();
        for (int n = 0; n < 48; n++) begin
            mem_address = 16'($urandom_range(0, 16'h3FFF));
            op          = random_op();
            id          = 4'($urandom_range(0, 15));
            sp          = 16'($urandom_range(16'h0400, 16'h0C00));
            if ($urandom_range(0, 3) == 0) begin
                interrupt_prio = 2'($urandom_range(0, 3));
            end
            tick();
        end
    endtask

    initial begin
        void'($urandom(82018));
        errors         = 0;
        checks         = 0;
        reset          = 1'b1;
        mem_address    = 16'h0000;
        sp             = 16'h0000;
        op             = OP_IMM;
        interrupt_prio = 2'd0;
        id             = 4'd0;
        csr_enable     = 1'b0;
        csr_addr       = '0;
        csr_op         = CSRRW;
        rs1_data       = 32'd0;
        rs1_zimm       = 5'd0;
        for (int j = 0; j < WORDS; j++) begin
            model_words[j] = 32'd0;
        end
        for (int p = 0; p < `MPU_PRIO_LEVELS; p++) begin
            model_slots[p] = 16'h0000;
        end
        model_last_prio = 2'd0;
        exp_f           = 1'b0;
        exp_ff          = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset();
        test_csr_ops();
        clear_table();
        test_permissions();
        test_bounds();
        test_stack();
        test_stream();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- mpu_assertions.sv
`timescale 1ns/10ps

module mpu_assertions import mpu_pkg::*; (
    input logic clk,
    input logic reset,
    input op_t  op,
    input logic mem_fault,
    input logic mem_fault_ff
);

    // Delayed copy trails the fault flag by one cycle
    property ff_follows_fault;
        @(posedge clk) disable iff (reset) mem_fault_ff == $past(mem_fault);
    endproperty

    // Only loads and stores may produce a fault
    property no_fault_without_mem_op;
        @(posedge clk) disable iff (reset)
            (op != OP_LOAD && op != OP_STORE) |=> !mem_fault;
    endproperty

    property flags_clear_after_reset;
        @(posedge clk) reset |=> (!mem_fault && !mem_fault_ff);
    endproperty

    assert property (ff_follows_fault)
        else $error("mem_fault_ff does not match mem_fault of the previous cycle");
    assert property (no_fault_without_mem_op)
        else $error("fault raised after a cycle with neither load nor store");
    assert property (flags_clear_after_reset)
        else $error("fault flags not clear in the cycle after reset");

endmodule

bind mpu_top mpu_assertions u_assertions (
    .clk          (clk),
    .reset        (reset),
    .op           (op),
    .mem_fault    (mem_fault),
    .mem_fault_ff (mem_fault_ff)
);

//--- mpu_top.sv
`timescale 1ns/10ps

module mpu_top import mpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] mem_address,
    input  logic [15:0] sp,
    input  op_t         op,
    input  logic [1:0]  interrupt_prio,
    input  logic [3:0]  id,
    input  logic        csr_enable,
    input  csr_addr_t   csr_addr,
    input  csr_op_t     csr_op,
    input  logic [31:0] rs1_data,
    input  logic [4:0]  rs1_zimm,
    output logic [31:0] csr_rdata,
    output logic        mem_fault,
    output logic        mem_fault_ff
);

    csr_bus_if   csr ();
    region_map_t region_map;
    logic [15:0] frame_bound;

    // Core side CSR instruction onto the internal bus
    assign csr.csr_enable = csr_enable;
    assign csr.csr_addr   = csr_addr;
    assign csr.csr_op     = csr_op;
    assign csr.rs1_data   = rs1_data;
    assign csr.rs1_zimm   = rs1_zimm;

    region_csr_bank u_csr_bank (
        .clk        (clk),
        .reset      (reset),
        .csr        (csr.sink),
        .csr_rdata  (csr_rdata),
        .region_map (region_map)
    );

    stack_frame_tracker u_frame (
        .clk            (clk),
        .reset          (reset),
        .interrupt_prio (interrupt_prio),
        .sp             (sp),
        .frame_bound    (frame_bound)
    );

    region_checker u_checker (
        .clk          (clk),
        .reset        (reset),
        .mem_address  (mem_address),
        .op           (op),
        .id           (id),
        .frame_bound  (frame_bound),
        .region_map   (region_map),
        .mem_fault    (mem_fault),
        .mem_fault_ff (mem_fault_ff)
    );

endmodule

//--- region_checker.sv
`timescale 1ns/10ps
`include "mpu_consts.svh"

module region_checker import mpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] mem_address,
    input  op_t         op,
    input  logic [3:0]  id,
    input  logic [15:0] frame_bound,
    input  region_map_t region_map,
    output logic        mem_fault,
    output logic        mem_fault_ff
);

    logic                 id_valid;
    logic                 is_load;
    logic                 is_mem;
    logic                 in_stack;
    logic [`MPU_ROWS-1:0] row_permit;
    logic                 fault_next;

    assign id_valid = (id < `MPU_MAPS);
    assign is_load  = (op == OP_LOAD);
    assign is_mem   = is_load || (op == OP_STORE);

    // Empty window when the frame sits below the stack top
    assign in_stack = (mem_address >= `MPU_STACK_TOP) && (mem_address <= frame_bound);

    always_comb begin
        region_t     row;
        logic [15:0] top;
        logic        in_range;
        row_permit = '0;
        for (int i = 0; i < `MPU_ROWS; i++) begin
            row = id_valid ? region_map[id][i] : '0;
            // End address wraps at 16 bits
            top      = row.base + {2'b00, row.length};
            in_range = (mem_address >= row.base) && (mem_address <= top);
            row_permit[i] = id_valid && in_range &&
                            (is_load ? row.read_en : row.write_en);
        end
    end

    assign fault_next = is_mem && !in_stack && !(|row_permit);

    // Fault flag and its delayed copy for the interrupt controller
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_fault    <= 1'b0;
            mem_fault_ff <= 1'b0;
        end else begin
            mem_fault    <= fault_next;
            mem_fault_ff <= mem_fault;
        end
    end

endmodule

//--- stack_frame_tracker.sv
`timescale 1ns/10ps
`include "mpu_consts.svh"

module stack_frame_tracker (
    input  logic        clk,
    input  logic        reset,
    input  logic [1:0]  interrupt_prio,
    input  logic [15:0] sp,
    output logic [15:0] frame_bound
);

    // Entry stack pointer per priority level
    logic [`MPU_PRIO_LEVELS-1:0][15:0] slots_q;
    logic [1:0]                        last_prio_q;
    logic                              prio_change;

    assign prio_change = (interrupt_prio != last_prio_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            slots_q     <= '0;
            last_prio_q <= 2'd0;
        end else begin
            last_prio_q <= interrupt_prio;
            // Record sp on entry to a new level
            if (prio_change) begin
                slots_q[interrupt_prio] <= sp;
            end
        end
    end

    // Bypass so the entry cycle already sees the new frame
    assign frame_bound = prio_change ? sp : slots_q[interrupt_prio];

endmodule

//--- region_csr_bank.sv
`timescale 1ns/10ps
`include "mpu_consts.svh"

module region_csr_bank import mpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    csr_bus_if.sink     csr,
    output logic [31:0] csr_rdata,
    output region_map_t region_map
);

    localparam int unsigned WORDS = `MPU_MAPS * `MPU_ROWS;
    localparam int unsigned IDX_W = $clog2(WORDS);

    // Word j holds map j / rows, row j % rows
    logic [WORDS-1:0][31:0] words_q;

    csr_addr_t          offset;
    logic               hit;
    logic [IDX_W-1:0]   index;
    logic [31:0]        operand;
    logic [31:0]        old_word;
    logic [31:0]        new_word;
    logic               wr_en;

    // Addresses below the base wrap to a large offset and miss
    assign offset = csr.csr_addr - `MPU_CSR_BASE;
    assign hit    = csr.csr_enable && (offset < WORDS);
    assign index  = offset[IDX_W-1:0];

    // Immediate forms use the zero-extended zimm field
    assign operand  = csr.csr_op[2] ? {27'b0, csr.rs1_zimm} : csr.rs1_data;
    assign old_word = hit ? words_q[index] : 32'b0;

    always_comb begin
        new_word = old_word;
        wr_en    = hit;
        case (csr.csr_op)
            CSRRW, CSRRWI: new_word = operand;
            CSRRS, CSRRSI: new_word = old_word | operand;
            CSRRC, CSRRCI: new_word = old_word & ~operand;
            // Reserved funct3, no write
            default:       wr_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            words_q <= '0;
        end else if (wr_en) begin
            words_q[index] <= new_word;
        end
    end

    assign csr_rdata = old_word;

    // Flat word order matches the packed map layout
    assign region_map = region_map_t'(words_q);

endmodule

//--- csr_bus_if.sv
`timescale 1ns/10ps

// One CSR instruction as decoded by the core
interface csr_bus_if import mpu_pkg::*; ();

    logic        csr_enable;
    csr_addr_t   csr_addr;
    csr_op_t     csr_op;
    logic [31:0] rs1_data;
    logic [4:0]  rs1_zimm;

    modport source (
        output csr_enable, csr_addr, csr_op, rs1_data, rs1_zimm
    );

    modport sink (
        input csr_enable, csr_addr, csr_op, rs1_data, rs1_zimm
    );

endinterface

//--- mpu_pkg.sv
`include "mpu_consts.svh"

package mpu_pkg;

    // Major opcodes seen by the MPU, only loads and stores are checked
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_IMM   = 7'b0010011,
        OP_STORE = 7'b0100011,
        OP_REG   = 7'b0110011
    } op_t;

    // CSR funct3 encodings
    typedef enum logic [2:0] {
        CSRRW  = 3'd1,
        CSRRS  = 3'd2,
        CSRRC  = 3'd3,
        CSRRWI = 3'd5,
        CSRRSI = 3'd6,
        CSRRCI = 3'd7
    } csr_op_t;

    typedef logic [11:0] csr_addr_t;

    // One region word, covers base .. base + length inclusive
    typedef struct packed {
        logic [15:0] base;
        logic [13:0] length;
        logic        write_en;
        logic        read_en;
    } region_t;

    typedef region_t [`MPU_MAPS-1:0][`MPU_ROWS-1:0] region_map_t;

endpackage

//--- mpu_consts.svh
`ifndef MPU_CONSTS_SVH
`define MPU_CONSTS_SVH

// Task maps in the region table, indexed by task id
`define MPU_MAPS 9

// Regions per task map
`define MPU_ROWS 4

// Lowest address of every stack window
`define MPU_STACK_TOP 16'd1280

// Interrupt priority levels, one entry stack pointer each
`define MPU_PRIO_LEVELS 4

// CSR address of region word 0
// Map k, row i lives at base + i + rows * k
`define MPU_CSR_BASE 12'h400

`endif
